// ==== source/exec_pkg.sv ====
// Execution cluster shared definitions
// Data and tag widths, the issue and result bundles, unit classes
// and the RV32 opcode constants used by the decoders
`default_nettype none

package exec_pkg;

    // ------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------
    // Operand and result word
    typedef logic [31:0] xlen_t;
    // Reorder buffer entry index
    typedef logic [4:0]  rob_tag_t;

    // Decoded instruction fields seen by the units
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } exec_op_t;

    // One issued operation, latched by a unit on start
    typedef struct packed {
        exec_op_t op;
        xlen_t    rs1;
        xlen_t    rs2;
        rob_tag_t tag;
    } issue_t;

    // One CDB broadcast
    typedef struct packed {
        rob_tag_t tag;
        xlen_t    data;
    } result_t;

    // Functional unit classes
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_DIV
    } fu_class_e;

    // ------------------------------------------------------------------
    // RV32 encodings
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// ==== source/exec_dispatch.sv ====
// Execution cluster dispatcher
// Decodes the operation class and starts the lowest free unit of it
`default_nettype none

module exec_dispatch import exec_pkg::*; #(
    parameter int NUM_ALU = 2,
    parameter int NUM_MUL = 1
) (
    input  wire logic                                issue_valid_i,
    input  wire exec_op_t                            op_i,
    input  wire logic [NUM_ALU+NUM_MUL:0]            busy_i,
    output logic      [NUM_ALU+NUM_MUL:0]            start_o,
    output logic                                     issue_ready_o
);

    // ALUs first, then multipliers, divider last
    localparam int NUM_UNITS = NUM_ALU + NUM_MUL + 1;
    localparam int DIV_IDX   = NUM_ALU + NUM_MUL;

    fu_class_e fu_class;
    int        lo_idx;
    int        hi_idx;

    // Class decode, only register-register OP carries M extension
    always_comb begin
        fu_class = FU_ALU;
        if (op_i.opcode == OPC_OP && op_i.funct7 == FUNCT7_MULDIV) begin
            // funct3 0..3 multiply, 4..7 divide/remainder
            fu_class = op_i.funct3[2] ? FU_DIV : FU_MUL;
        end
    end

    // Unit index window of the selected class
    always_comb begin
        case (fu_class)
            FU_MUL: begin
                lo_idx = NUM_ALU;
                hi_idx = DIV_IDX - 1;
            end
            FU_DIV: begin
                lo_idx = DIV_IDX;
                hi_idx = DIV_IDX;
            end
            default: begin
                lo_idx = 0;
                hi_idx = NUM_ALU - 1;
            end
        endcase
    end

    // Lowest free unit inside the window wins
    always_comb begin
        logic found;
        found   = 1'b0;
        start_o = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!found && i >= lo_idx && i <= hi_idx && !busy_i[i]) begin
                found      = 1'b1;
                start_o[i] = issue_valid_i;
            end
        end
        issue_ready_o = found;
    end

endmodule

`default_nettype wire

// ==== source/exec_alu.sv ====
// Single-cycle integer ALU
// Computes the RV32I register/immediate operation on start and
// holds the result until the CDB arbiter grants it
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire logic   start_i,
    input  wire issue_t issue_i,
    input  wire logic   grant_i,
    output logic        busy_o,
    output logic        done_o,
    output result_t     result_o
);

    logic     busy_q;
    xlen_t    data_q;
    rob_tag_t tag_q;
    xlen_t    alu_res;
    logic     is_arith;

    assign is_arith = (issue_i.op.opcode == OPC_OP) || (issue_i.op.opcode == OPC_OP_IMM);

    // Operation select from funct3
    always_comb begin
        case (is_arith ? issue_i.op.funct3 : 3'b000)
            3'b000: begin
                // SUB only exists in register form
                if (is_arith && issue_i.op.opcode == OPC_OP && issue_i.op.funct7[5])
                    alu_res = issue_i.rs1 - issue_i.rs2;
                else
                    alu_res = issue_i.rs1 + issue_i.rs2;
            end
            3'b001: alu_res = issue_i.rs1 << issue_i.rs2[4:0];
            3'b010: alu_res = xlen_t'($signed(issue_i.rs1) < $signed(issue_i.rs2));
            3'b011: alu_res = xlen_t'(issue_i.rs1 < issue_i.rs2);
            3'b100: alu_res = issue_i.rs1 ^ issue_i.rs2;
            3'b101: begin
                // funct7 bit 5 picks arithmetic shift
                if (issue_i.op.funct7[5])
                    alu_res = xlen_t'($signed(issue_i.rs1) >>> issue_i.rs2[4:0]);
                else
                    alu_res = issue_i.rs1 >> issue_i.rs2[4:0];
            end
            3'b110: alu_res = issue_i.rs1 | issue_i.rs2;
            default: alu_res = issue_i.rs1 & issue_i.rs2;
        endcase
    end

    // Busy from start until the grant edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
        end else if (grant_i) begin
            busy_q <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            data_q <= alu_res;
            tag_q  <= issue_i.tag;
        end
    end

    // Result is ready the cycle after start
    assign busy_o   = busy_q;
    assign done_o   = busy_q;
    assign result_o = '{tag: tag_q, data: data_q};

endmodule

`default_nettype wire

// ==== source/exec_mul.sv ====
// Fixed-latency multiplier unit
// MUL, MULH, MULHSU and MULHU; result appears MUL_LATENCY cycles after
// start and is held until granted
`default_nettype none

module exec_mul import exec_pkg::*; #(
    parameter int MUL_LATENCY = 3
) (
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire logic   start_i,
    input  wire issue_t issue_i,
    input  wire logic   grant_i,
    output logic        busy_o,
    output logic        done_o,
    output result_t     result_o
);

    // Counter holds latency minus one
    localparam int CNT_W = (MUL_LATENCY > 1) ? $clog2(MUL_LATENCY) : 1;

    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;
    xlen_t             a_q;
    xlen_t             b_q;
    logic [2:0]        funct3_q;
    rob_tag_t          tag_q;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] product;
    xlen_t             mul_res;

    // Control, the counter runs down while busy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(MUL_LATENCY - 1);
        end else if (busy_q && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (grant_i) begin
            busy_q <= 1'b0;
        end
    end

    // Operands captured on start
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q      <= issue_i.rs1;
            b_q      <= issue_i.rs2;
            funct3_q <= issue_i.op.funct3;
            tag_q    <= issue_i.tag;
        end
    end

    // Sign extension: rs1 signed for MULH/MULHSU, rs2 only for MULH
    assign a_ext = {(funct3_q == 3'b001 || funct3_q == 3'b010) & a_q[31], a_q};
    assign b_ext = {(funct3_q == 3'b001) & b_q[31], b_q};
    assign product = a_ext * b_ext;

    // Low word for MUL, high word for the rest
    assign mul_res = (funct3_q == 3'b000) ? product[31:0] : product[63:32];

    assign busy_o   = busy_q;
    assign done_o   = busy_q && (cnt_q == '0);
    assign result_o = '{tag: tag_q, data: mul_res};

endmodule

`default_nettype wire

// ==== source/exec_div.sv ====
// Iterative divider unit
// Radix-2 restoring division for DIV, DIVU, REM and REMU
// One load cycle plus 32 shift-subtract steps, then held until granted
`default_nettype none

module exec_div import exec_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire logic   start_i,
    input  wire issue_t issue_i,
    input  wire logic   grant_i,
    output logic        busy_o,
    output logic        done_o,
    output result_t     result_o
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e  state_q;
    logic [4:0]  step_q;
    xlen_t       rem_q;
    xlen_t       quo_q;
    xlen_t       divisor_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        sel_rem_q;
    rob_tag_t    tag_q;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [32:0] shifted;
    logic [32:0] trial;
    logic        take;
    xlen_t       quo_fix;
    xlen_t       rem_fix;

    // ------------------------------------------------------------------
    // Operand conditioning at load
    // ------------------------------------------------------------------
    // Odd funct3 is the unsigned form
    assign is_signed = ~issue_i.op.funct3[0];
    assign a_neg     = is_signed & issue_i.rs1[31];
    assign b_neg     = is_signed & issue_i.rs2[31];

    // ------------------------------------------------------------------
    // One restoring step
    // ------------------------------------------------------------------
    // Bring down next dividend bit from the top of the quotient register
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, divisor_q};
    assign take    = shifted >= {1'b0, divisor_q};

    // FSM
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        step_q  <= 5'd31;
                    end
                end
                DIV_RUN: begin
                    if (step_q == 5'd0)
                        state_q <= DIV_DONE;
                    step_q <= step_q - 5'd1;
                end
                DIV_DONE: begin
                    if (grant_i)
                        state_q <= DIV_IDLE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // Datapath, magnitudes loaded on start
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q     <= '0;
            quo_q     <= a_neg ? -issue_i.rs1 : issue_i.rs1;
            divisor_q <= b_neg ? -issue_i.rs2 : issue_i.rs2;
            // Divide by zero keeps an all-ones quotient
            neg_quo_q <= (a_neg ^ b_neg) && (issue_i.rs2 != '0);
            // Remainder follows the dividend sign
            neg_rem_q <= a_neg;
            sel_rem_q <= issue_i.op.funct3[1];
            tag_q     <= issue_i.tag;
        end else if (state_q == DIV_RUN) begin
            rem_q <= take ? trial[31:0] : shifted[31:0];
            quo_q <= {quo_q[30:0], take};
        end
    end

    // Sign fix-up; x/0 leaves |x| in the remainder, so REM gives x back
    // Most negative / -1 lands on 0x80000000 and remainder zero by itself
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign busy_o   = (state_q != DIV_IDLE);
    assign done_o   = (state_q == DIV_DONE);
    assign result_o = '{tag: tag_q, data: sel_rem_q ? rem_fix : quo_fix};

endmodule

`default_nettype wire

// ==== source/exec_result_arbiter.sv ====
// CDB result arbiter
// Fixed priority, lowest unit index first, one result per cycle
`default_nettype none

module exec_result_arbiter import exec_pkg::*; #(
    parameter int NUM_ALU = 2,
    parameter int NUM_MUL = 1
) (
    input  wire logic    [NUM_ALU+NUM_MUL:0]   done_i,
    input  wire result_t                       results_i [NUM_ALU+NUM_MUL+1],
    output logic         [NUM_ALU+NUM_MUL:0]   grant_o,
    output logic                               result_valid_o,
    output result_t                            result_o
);

    localparam int NUM_UNITS = NUM_ALU + NUM_MUL + 1;

    // ------------------------------------------------------------------
    // Priority select
    // ------------------------------------------------------------------
    always_comb begin
        grant_o        = '0;
        result_valid_o = 1'b0;
        result_o       = '0;
        // First done unit wins, others keep holding
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (done_i[i] && !result_valid_o) begin
                grant_o[i]     = 1'b1;
                result_valid_o = 1'b1;
                result_o       = results_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/exec_cluster.sv ====
// Execution cluster top level
// Dispatcher, ALU and multiplier arrays, one divider and the CDB arbiter
`default_nettype none

module exec_cluster import exec_pkg::*; #(
    parameter int NUM_ALU     = 2,
    parameter int NUM_MUL     = 1,
    parameter int MUL_LATENCY = 3
) (
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire logic   issue_valid_i,
    input  wire issue_t issue_i,
    output logic        issue_ready_o,
    output logic        result_valid_o,
    output result_t     result_o
);

    localparam int NUM_UNITS = NUM_ALU + NUM_MUL + 1;
    localparam int DIV_IDX   = NUM_ALU + NUM_MUL;

    // Per-unit handshake levels
    logic [NUM_UNITS-1:0] start;
    logic [NUM_UNITS-1:0] busy;
    logic [NUM_UNITS-1:0] done;
    logic [NUM_UNITS-1:0] grant;
    result_t              unit_results [NUM_UNITS];

    exec_dispatch #(
        .NUM_ALU (NUM_ALU),
        .NUM_MUL (NUM_MUL)
    ) u_dispatch (
        .issue_valid_i (issue_valid_i),
        .op_i          (issue_i.op),
        .busy_i        (busy),
        .start_o       (start),
        .issue_ready_o (issue_ready_o)
    );

    // ------------------------------------------------------------------
    // Functional units
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_ALU; i++) begin : gen_alu
        exec_alu u_alu (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .start_i  (start[i]),
            .issue_i  (issue_i),
            .grant_i  (grant[i]),
            .busy_o   (busy[i]),
            .done_o   (done[i]),
            .result_o (unit_results[i])
        );
    end

    // Multipliers follow the ALUs
    for (genvar i = 0; i < NUM_MUL; i++) begin : gen_mul
        exec_mul #(
            .MUL_LATENCY (MUL_LATENCY)
        ) u_mul (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .start_i  (start[NUM_ALU+i]),
            .issue_i  (issue_i),
            .grant_i  (grant[NUM_ALU+i]),
            .busy_o   (busy[NUM_ALU+i]),
            .done_o   (done[NUM_ALU+i]),
            .result_o (unit_results[NUM_ALU+i])
        );
    end

    // Single divider, lowest CDB priority
    exec_div u_div (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .start_i  (start[DIV_IDX]),
        .issue_i  (issue_i),
        .grant_i  (grant[DIV_IDX]),
        .busy_o   (busy[DIV_IDX]),
        .done_o   (done[DIV_IDX]),
        .result_o (unit_results[DIV_IDX])
    );

    exec_result_arbiter #(
        .NUM_ALU (NUM_ALU),
        .NUM_MUL (NUM_MUL)
    ) u_arbiter (
        .done_i         (done),
        .results_i      (unit_results),
        .grant_o        (grant),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

// ==== verification/exec_clock_gen.sv ====
// Testbench clock source
// Free-running clock, low at time zero
`default_nettype none

module exec_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== verification/exec_cluster_tb.sv ====
// Execution cluster testbench
// Directed and LFSR-driven operations against a reference model,
// tag scoreboard checked by concurrent assertions on the falling edge
`default_nettype none

module exec_cluster_tb import exec_pkg::*; ();

    localparam int MUL_LATENCY    = 3;
    localparam int DIV_LATENCY    = 33;
    localparam int NUM_RANDOM     = 120;
    // About 200 operations at 40 cycles each
    localparam int MAX_OPS        = 200;
    localparam int TIMEOUT_CYCLES = MAX_OPS * 40;

    logic    clk;
    logic    reset_i;
    logic    issue_valid_i;
    issue_t  issue_i;
    logic    issue_ready_o;
    logic    result_valid_o;
    result_t result_o;

    // Scoreboard, indexed by ROB tag
    logic [31:0] pending;
    logic [31:0] isolated_tag;
    xlen_t       expected [32];
    int          issue_cycle [32];
    int          exp_latency [32];
    int          cycles = 0;
    logic        prev_reset;
    int          value_errors = 0;
    int          timing_errors = 0;

    // Stimulus controls
    logic        isolated;
    logic        probe_en;
    logic        probe_exp;
    logic        hold_en;
    rob_tag_t    hold_tag;
    rob_tag_t    next_tag;
    logic [15:0] lfsr_state;

    exec_clock_gen #(.PERIOD(40)) u_clock (.clk_o(clk));

    exec_cluster dut (
        .clk_i          (clk),
        .reset_i        (reset_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .issue_ready_o  (issue_ready_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic fu_class_e op_class(input exec_op_t op);
        if (op.opcode == OPC_OP && op.funct7 == FUNCT7_MULDIV)
            return op.funct3[2] ? FU_DIV : FU_MUL;
        return FU_ALU;
    endfunction

    function automatic int latency_of(input exec_op_t op);
        case (op_class(op))
            FU_MUL:  return MUL_LATENCY;
            FU_DIV:  return DIV_LATENCY;
            default: return 1;
        endcase
    endfunction

    function automatic xlen_t ref_result(input exec_op_t op, input xlen_t a, input xlen_t b);
        logic [63:0] prod;
        logic [4:0]  sh;
        sh = b[4:0];
        case (op_class(op))
            FU_MUL: begin
                // 64-bit product of the extended operands, wrap is harmless
                case (op.funct3)
                    3'd0:    return a * b;
                    3'd1:    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    3'd2:    prod = {{32{a[31]}}, a} * {32'd0, b};
                    default: prod = {32'd0, a} * {32'd0, b};
                endcase
                return prod[63:32];
            end
            FU_DIV: begin
                // RV32M corner cases never trap
                if (b == 32'd0)
                    return op.funct3[1] ? a : 32'hFFFF_FFFF;
                if (!op.funct3[0] && a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
                    return op.funct3[1] ? 32'd0 : a;
                case (op.funct3)
                    3'd4:    return $signed(a) / $signed(b);
                    3'd5:    return a / b;
                    3'd6:    return $signed(a) % $signed(b);
                    default: return a % b;
                endcase
            end
            default: begin
                // Other opcodes stand in for address arithmetic
                if (op.opcode != OPC_OP && op.opcode != OPC_OP_IMM)
                    return a + b;
                case (op.funct3)
                    3'd0:    return (op.opcode == OPC_OP && op.funct7[5]) ? a - b : a + b;
                    3'd1:    return a << sh;
                    3'd2:    return {31'd0, $signed(a) < $signed(b)};
                    3'd3:    return {31'd0, a < b};
                    3'd4:    return a ^ b;
                    3'd5:    return op.funct7[5] ? xlen_t'($signed(a) >>> sh) : a >> sh;
                    3'd6:    return a | b;
                    default: return a & b;
                endcase
            end
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Extremes and zero show up often
    function automatic xlen_t rand_operand();
        case (rand_bits(3))
            0:       return 32'd0;
            1:       return 32'h8000_0000;
            2:       return 32'hFFFF_FFFF;
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic exec_op_t rand_op();
        exec_op_t op;
        op.funct3 = 3'(rand_bits(3));
        op.opcode = rand_bits(1) ? OPC_OP : OPC_OP_IMM;
        op.funct7 = rand_bits(1) ? 7'h20 : 7'h00;
        // Roughly a quarter of the ops go to the M extension
        if (op.opcode == OPC_OP && rand_bits(1))
            op.funct7 = FUNCT7_MULDIV;
        return op;
    endfunction

    function automatic exec_op_t mk_op(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [6:0] f7);
        return '{opcode: opc, funct3: f3, funct7: f7};
    endfunction

    // ------------------------------------------------------------------
    // Scoreboard update, one negedge ahead of the edge it stands for
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        prev_reset <= reset_i;
        cycles     <= cycles + 1;
        if (reset_i) begin
            pending      <= '0;
            isolated_tag <= '0;
        end else begin
            if (result_valid_o && !$isunknown(result_o.tag))
                pending[result_o.tag] <= 1'b0;
            if (issue_valid_i && issue_ready_o) begin
                pending[issue_i.tag]      <= 1'b1;
                expected[issue_i.tag]     <= ref_result(issue_i.op, issue_i.rs1, issue_i.rs2);
                issue_cycle[issue_i.tag]  <= cycles;
                exp_latency[issue_i.tag]  <= latency_of(issue_i.op);
                isolated_tag[issue_i.tag] <= isolated;
            end
        end
    end

    always @(negedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // Cleared on first broadcast, so a repeat also trips this
    tag_issued: assert property (@(negedge clk) disable iff (reset_i)
        result_valid_o |-> (!$isunknown(result_o.tag) && pending[result_o.tag]))
        else begin
            value_errors++;
            $display("CHECK FAILED at %0t: tag %0d on CDB not outstanding", $time, result_o.tag);
        end

    data_match: assert property (@(negedge clk) disable iff (reset_i)
        result_valid_o |-> (result_o.data == expected[result_o.tag]))
        else begin
            value_errors++;
            $display("CHECK FAILED at %0t: tag %0d data %h, expected %h", $time,
                     result_o.tag, result_o.data, expected[result_o.tag]);
        end

    latency_isolated: assert property (@(negedge clk) disable iff (reset_i)
        (result_valid_o && isolated_tag[result_o.tag])
            |-> (cycles - issue_cycle[result_o.tag] == exp_latency[result_o.tag]))
        else begin
            timing_errors++;
            $display("CHECK FAILED at %0t: tag %0d took %0d cycles, expected %0d", $time,
                     result_o.tag, cycles - issue_cycle[result_o.tag],
                     exp_latency[result_o.tag]);
        end

    quiet_in_reset: assert property (@(negedge clk)
        (reset_i || prev_reset) |-> !result_valid_o)
        else begin
            timing_errors++;
            $display("CHECK FAILED at %0t: result_valid_o high around reset", $time);
        end

    ready_probe: assert property (@(negedge clk) disable iff (reset_i)
        probe_en |-> (issue_ready_o == probe_exp))
        else begin
            timing_errors++;
            $display("CHECK FAILED at %0t: issue_ready_o %b for funct3 %0d, expected %b",
                     $time, issue_ready_o, issue_i.op.funct3, probe_exp);
        end

    div_overlap: assert property (@(negedge clk) disable iff (reset_i)
        hold_en |-> pending[hold_tag])
        else begin
            timing_errors++;
            $display("CHECK FAILED at %0t: divide tag %0d retired before other ops", $time,
                     hold_tag);
        end

    // ------------------------------------------------------------------
    // Stimulus tasks, all entered 2 units after a rising edge
    // ------------------------------------------------------------------
    task automatic send_op(input exec_op_t op, input xlen_t a, input xlen_t b);
        // Never reuse a tag still in flight
        while (pending[next_tag]) begin
            @(posedge clk);
            #2;
        end
        issue_i       = '{op: op, rs1: a, rs2: b, tag: next_tag};
        issue_valid_i = 1'b1;
        @(negedge clk);
        while (!issue_ready_o)
            @(negedge clk);
        @(posedge clk);
        #2;
        issue_valid_i = 1'b0;
        next_tag      = next_tag + 5'd1;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #2;
        end while (pending != '0);
    endtask

    task automatic run_isolated(input exec_op_t op, input xlen_t a, input xlen_t b);
        isolated = 1'b1;
        send_op(op, a, b);
        isolated = 1'b0;
        wait_idle();
    endtask

    // Shows an op class with valid low for one cycle
    task automatic probe_ready(input exec_op_t op, input logic exp);
        issue_i.op = op;
        probe_exp  = exp;
        probe_en   = 1'b1;
        @(posedge clk);
        #2;
        probe_en   = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        exec_op_t op;
        xlen_t    a;
        xlen_t    b;
        xlen_t    edge_a [5];
        xlen_t    edge_b [5];

        lfsr_state    = 16'd75;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        isolated      = 1'b0;
        probe_en      = 1'b0;
        probe_exp     = 1'b0;
        hold_en       = 1'b0;
        hold_tag      = '0;
        next_tag      = '0;
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // Every class free right after reset
        probe_ready(mk_op(OPC_OP, 3'd0, 7'h00), 1'b1);
        probe_ready(mk_op(OPC_OP, 3'd0, FUNCT7_MULDIV), 1'b1);
        probe_ready(mk_op(OPC_OP, 3'd4, FUNCT7_MULDIV), 1'b1);

        // ALU edge operands
        run_isolated(mk_op(OPC_OP, 3'd0, 7'h20), 32'd0, 32'd1);
        run_isolated(mk_op(OPC_OP_IMM, 3'd0, 7'h20), 32'd5, 32'd3);
        run_isolated(mk_op(OPC_OP, 3'd5, 7'h20), 32'h8000_0000, 32'd31);
        run_isolated(mk_op(OPC_OP_IMM, 3'd5, 7'h00), 32'h8000_0000, 32'd31);
        run_isolated(mk_op(OPC_OP, 3'd2, 7'h00), 32'hFFFF_FFFF, 32'd1);
        run_isolated(mk_op(OPC_OP, 3'd3, 7'h00), 32'd1, 32'hFFFF_FFFF);
        run_isolated(mk_op(OPC_OP, 3'd2, 7'h00), 32'h8000_0000, 32'h7FFF_FFFF);
        run_isolated(mk_op(7'b0000011, 3'd2, 7'h00), 32'd100, 32'd24);

        // Multiply and divide extremes, incl. x/0 and min/-1
        edge_a = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFF9, 32'hFFFF_FFF9};
        edge_b = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd0, 32'd2};
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 5; k++)
                run_isolated(mk_op(OPC_OP, 3'(f3), FUNCT7_MULDIV), edge_a[k], edge_b[k]);
        end

        // Divider busy, other classes keep flowing
        send_op(mk_op(OPC_OP, 3'd4, FUNCT7_MULDIV), 32'd1000, 32'd7);
        hold_tag = next_tag - 5'd1;
        probe_ready(mk_op(OPC_OP, 3'd5, FUNCT7_MULDIV), 1'b0);
        probe_ready(mk_op(OPC_OP, 3'd0, 7'h00), 1'b1);
        probe_ready(mk_op(OPC_OP, 3'd0, FUNCT7_MULDIV), 1'b1);
        send_op(mk_op(OPC_OP, 3'd0, 7'h20), 32'd50, 32'd8);
        send_op(mk_op(OPC_OP, 3'd1, FUNCT7_MULDIV), 32'h1234_5678, 32'h9ABC_DEF0);
        send_op(mk_op(OPC_OP_IMM, 3'd6, 7'h00), 32'hF0F0_0000, 32'h0000_0F0F);
        while ((pending & ~(32'd1 << hold_tag)) != '0) begin
            @(posedge clk);
            #2;
        end
        hold_en = 1'b1;
        @(posedge clk);
        #2;
        hold_en = 1'b0;
        wait_idle();

        // Back-to-back mixed burst
        for (int n = 0; n < NUM_RANDOM; n++) begin
            op = rand_op();
            a  = rand_operand();
            b  = rand_operand();
            send_op(op, a, b);
        end
        wait_idle();

        repeat (2) @(posedge clk);
        $display("Errors: %0d value, %0d timing", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_cluster.f ====
source/exec_pkg.sv
source/exec_dispatch.sv
source/exec_alu.sv
source/exec_mul.sv
source/exec_div.sv
source/exec_result_arbiter.sv
source/exec_cluster.sv
verification/exec_clock_gen.sv
verification/exec_cluster_tb.sv

// ==== Makefile ====
# Verilator build and run for the execution cluster testbench

VERILATOR ?= verilator
TOP       ?= exec_cluster_tb
FILELIST  ?= exec_cluster.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)
